// ==== src/cpu_pkg.sv ====
package cpu_pkg;

  localparam int pc_width     = 13;
  localparam int rom_width    = 12;
  localparam int nibble_width = 4;
  localparam int ptr_width    = 12;
  localparam int imm_width    = 8;

  typedef enum logic [3:0] {
    nop,
    lda_i,
    ldb_i,
    ldx_i,
    ldy_i,
    add_r,
    sub_r,
    and_r,
    ld_r,
    st_r,
    inc_p,
    xab,
    jmp,
    jz,
    jc,
    op_reserved
  } opcode_e;

  // r_mx and r_my address the data memory through x and y
  typedef enum logic [1:0] {
    r_a,
    r_b,
    r_mx,
    r_my
  } operand_e;

  typedef struct packed {
    opcode_e     opcode;
    operand_e    r;
    logic [5:0]  unused;
  } reg_form_t;

  typedef struct packed {
    opcode_e                opcode;
    logic [imm_width-1:0]   imm;
  } imm_form_t;

  // one ROM word, read as a register form or an immediate form
  typedef union packed {
    reg_form_t reg_form;
    imm_form_t imm_form;
  } instr_u;

  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_pass
  } alu_op_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    a_we;
    logic    b_we;
    logic    x_we;
    logic    y_we;
    logic    flags_we;
    logic    inc_x;
    logic    inc_y;
    logic    mem_we;
    logic    mem_sel;
    logic    load_imm;
    logic    pc_inc;
    logic    pc_branch;
  } ctrl_t;

  typedef struct packed {
    logic [pc_width-1:0]     pc;
    logic [nibble_width-1:0] a;
    logic [nibble_width-1:0] b;
    logic [ptr_width-1:0]    x;
    logic [ptr_width-1:0]    y;
    logic                    carry;
    logic                    zero;
  } cpu_state_t;

endpackage

// ==== src/cpu_microcode.sv ====
`timescale 1ns/1ps

module cpu_microcode import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic [rom_width-1:0] rom_data,
  output ctrl_t                ctrl,
  output opcode_e              opcode,
  output logic [imm_width-1:0] imm,
  output operand_e             operand,
  output logic                 instr_done
);

  typedef enum logic [1:0] {
    st_fetch,
    st_decode,
    st_mem_read,
    st_execute
  } step_e;

  step_e  step;
  step_e  step_next;
  instr_u rom_word;
  instr_u instr_q;
  instr_u cur;
  logic   reads_mem;

  assign rom_word = rom_data;

  // the word is only on the ROM bus during decode, later steps use the latched copy
  assign cur = (step == st_decode) ? rom_word : instr_q;

  assign opcode = cur.reg_form.opcode;
  assign imm    = cur.imm_form.imm;

  // xab routes b through the ALU pass path into a
  assign operand = (opcode == xab) ? r_b : cur.reg_form.r;

  always_comb begin
    case (opcode)
      add_r, sub_r, and_r, ld_r: begin
        reads_mem = (cur.reg_form.r == r_mx) || (cur.reg_form.r == r_my);
      end
      default: begin
        reads_mem = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (step)
      st_fetch:    step_next = st_decode;
      st_decode:   step_next = reads_mem ? st_mem_read : st_execute;
      st_mem_read: step_next = st_execute;
      default:     step_next = st_fetch;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      step    <= st_fetch;
      instr_q <= '0;
    end else begin
      step <= step_next;
      if (step == st_decode) begin
        instr_q <= rom_word;
      end
    end
  end

  always_comb begin
    ctrl         = '0;
    ctrl.alu_op  = alu_pass;
    // the pointer is chosen early so a read issued in decode sees a stable address
    ctrl.mem_sel = (cur.reg_form.r == r_my);
    if (step == st_execute) begin
      ctrl.pc_inc = 1'b1;
      case (opcode)
        lda_i: begin
          ctrl.a_we     = 1'b1;
          ctrl.load_imm = 1'b1;
        end
        ldb_i: begin
          ctrl.b_we     = 1'b1;
          ctrl.load_imm = 1'b1;
        end
        ldx_i: begin
          ctrl.x_we     = 1'b1;
          ctrl.load_imm = 1'b1;
        end
        ldy_i: begin
          ctrl.y_we     = 1'b1;
          ctrl.load_imm = 1'b1;
        end
        add_r, sub_r, and_r: begin
          ctrl.alu_op   = (opcode == add_r) ? alu_add :
                          (opcode == sub_r) ? alu_sub : alu_and;
          ctrl.a_we     = 1'b1;
          ctrl.flags_we = 1'b1;
        end
        ld_r: begin
          ctrl.a_we = 1'b1;
        end
        st_r: begin
          // register operands have nowhere to store to
          ctrl.mem_we = (cur.reg_form.r == r_mx) || (cur.reg_form.r == r_my);
        end
        inc_p: begin
          ctrl.inc_x = ~cur.reg_form.r[0];
          ctrl.inc_y = cur.reg_form.r[0];
        end
        xab: begin
          ctrl.a_we = 1'b1;
          ctrl.b_we = 1'b1;
        end
        jmp, jz, jc: begin
          ctrl.pc_inc    = 1'b0;
          ctrl.pc_branch = 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  assign instr_done = (step == st_execute);

endmodule

// ==== src/cpu_regs.sv ====
`timescale 1ns/1ps

module cpu_regs import cpu_pkg::*; (
  input  logic                    clk,
  input  logic                    arst_n,
  input  ctrl_t                   ctrl,
  input  logic [imm_width-1:0]    imm,
  input  operand_e                operand,
  input  logic [nibble_width-1:0] alu_result,
  input  logic                    alu_carry,
  input  logic                    alu_zero,
  input  logic [nibble_width-1:0] memory_read_data,
  input  logic [pc_width-1:0]     pc,
  output cpu_state_t              state,
  output logic [nibble_width-1:0] operand_value
);

  logic [nibble_width-1:0] a;
  logic [nibble_width-1:0] b;
  logic [ptr_width-1:0]    x;
  logic [ptr_width-1:0]    y;
  logic                    carry;
  logic                    zero;
  logic [nibble_width-1:0] imm_nibble;
  logic [ptr_width-1:0]    imm_ptr;

  assign imm_nibble = imm[nibble_width-1:0];
  assign imm_ptr    = {{(ptr_width - imm_width){1'b0}}, imm};

  always_comb begin
    case (operand)
      r_a:     operand_value = a;
      r_b:     operand_value = b;
      default: operand_value = memory_read_data;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a     <= '0;
      b     <= '0;
      x     <= '0;
      y     <= '0;
      carry <= 1'b0;
      zero  <= 1'b0;
    end else begin
      if (ctrl.a_we) begin
        a <= ctrl.load_imm ? imm_nibble : alu_result;
      end
      // apart from ldb_i, b is only written by the exchange
      if (ctrl.b_we) begin
        b <= ctrl.load_imm ? imm_nibble : a;
      end
      if (ctrl.x_we) begin
        x <= imm_ptr;
      end else if (ctrl.inc_x) begin
        x <= x + 1'b1;
      end
      if (ctrl.y_we) begin
        y <= imm_ptr;
      end else if (ctrl.inc_y) begin
        y <= y + 1'b1;
      end
      if (ctrl.flags_we) begin
        zero <= alu_zero;
        // and leaves carry as it was
        if (ctrl.alu_op != alu_and) begin
          carry <= alu_carry;
        end
      end
    end
  end

  always_comb begin
    state.pc    = pc;
    state.a     = a;
    state.b     = b;
    state.x     = x;
    state.y     = y;
    state.carry = carry;
    state.zero  = zero;
  end

endmodule

// ==== src/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
  input  alu_op_e                 alu_op,
  input  logic [nibble_width-1:0] a,
  input  logic [nibble_width-1:0] b,
  output logic [nibble_width-1:0] result,
  output logic                    carry,
  output logic                    zero
);

  // one extra bit holds the carry out or the borrow
  logic [nibble_width:0] wide;

  always_comb begin
    case (alu_op)
      alu_add: begin
        wide = {1'b0, a} + {1'b0, b};
      end
      alu_sub: begin
        // top bit goes high when b is larger than a
        wide = {1'b0, a} - {1'b0, b};
      end
      alu_and: begin
        wide = {1'b0, a & b};
      end
      default: begin
        wide = {1'b0, b};
      end
    endcase
  end

  assign result = wide[nibble_width-1:0];
  assign carry  = wide[nibble_width];
  assign zero   = (wide[nibble_width-1:0] == '0);

endmodule

// ==== src/cpu_addr_unit.sv ====
`timescale 1ns/1ps

module cpu_addr_unit import cpu_pkg::*; (
  input  logic                    clk,
  input  logic                    arst_n,
  input  ctrl_t                   ctrl,
  input  logic [imm_width-1:0]    imm,
  input  opcode_e                 opcode,
  input  logic                    carry,
  input  logic                    zero,
  input  logic [ptr_width-1:0]    x,
  input  logic [ptr_width-1:0]    y,
  input  logic [nibble_width-1:0] a,
  output logic [pc_width-1:0]     pc,
  output logic [pc_width-1:0]     rom_addr,
  output logic [ptr_width-1:0]    memory_addr,
  output logic                    memory_write_en,
  output logic [nibble_width-1:0] memory_write_data
);

  logic taken;

  always_comb begin
    case (opcode)
      jmp:     taken = 1'b1;
      jz:      taken = zero;
      jc:      taken = carry;
      default: taken = 1'b0;
    endcase
  end

  // branches stay inside the current 256-word page
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (ctrl.pc_branch && taken) begin
      pc <= {pc[pc_width-1:imm_width], imm};
    end else if (ctrl.pc_inc || ctrl.pc_branch) begin
      pc <= pc + 1'b1;
    end
  end

  assign rom_addr = pc;

  assign memory_addr       = ctrl.mem_sel ? y : x;
  assign memory_write_en   = ctrl.mem_we;
  assign memory_write_data = a;

endmodule

// ==== src/cpu.sv ====
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
  input  logic                    clk,
  input  logic                    arst_n,
  output logic [pc_width-1:0]     rom_addr,
  input  logic [rom_width-1:0]    rom_data,
  output logic                    memory_write_en,
  output logic [ptr_width-1:0]    memory_addr,
  output logic [nibble_width-1:0] memory_write_data,
  input  logic [nibble_width-1:0] memory_read_data,
  output cpu_state_t              state,
  output logic                    instr_done
);

  ctrl_t                   ctrl;
  opcode_e                 opcode;
  operand_e                operand;
  logic [imm_width-1:0]    imm;
  logic [nibble_width-1:0] alu_result;
  logic                    alu_carry;
  logic                    alu_zero;
  logic [nibble_width-1:0] operand_value;
  logic [pc_width-1:0]     pc;

  cpu_microcode i_microcode (
    .clk        (clk),
    .arst_n     (arst_n),
    .rom_data   (rom_data),
    .ctrl       (ctrl),
    .opcode     (opcode),
    .imm        (imm),
    .operand    (operand),
    .instr_done (instr_done)
  );

  cpu_regs i_regs (
    .clk              (clk),
    .arst_n           (arst_n),
    .ctrl             (ctrl),
    .imm              (imm),
    .operand          (operand),
    .alu_result       (alu_result),
    .alu_carry        (alu_carry),
    .alu_zero         (alu_zero),
    .memory_read_data (memory_read_data),
    .pc               (pc),
    .state            (state),
    .operand_value    (operand_value)
  );

  cpu_alu i_alu (
    .alu_op (ctrl.alu_op),
    .a      (state.a),
    .b      (operand_value),
    .result (alu_result),
    .carry  (alu_carry),
    .zero   (alu_zero)
  );

  cpu_addr_unit i_addr_unit (
    .clk               (clk),
    .arst_n            (arst_n),
    .ctrl              (ctrl),
    .imm               (imm),
    .opcode            (opcode),
    .carry             (state.carry),
    .zero              (state.zero),
    .x                 (state.x),
    .y                 (state.y),
    .a                 (state.a),
    .pc                (pc),
    .rom_addr          (rom_addr),
    .memory_addr       (memory_addr),
    .memory_write_en   (memory_write_en),
    .memory_write_data (memory_write_data)
  );

endmodule

// ==== tests/bench_assert.sv ====
`timescale 1ns/1ps

module cpu_bus_checks import cpu_pkg::*; (
  input logic                clk,
  input logic                arst_n,
  input logic                memory_write_en,
  input logic                instr_done,
  input logic [pc_width-1:0] rom_addr,
  input cpu_state_t          state
);

  assert property (@(posedge clk) !arst_n |-> !memory_write_en)
    else $error("memory_write_en high while in reset");

  assert property (@(posedge clk) disable iff (!arst_n) instr_done |=> !instr_done)
    else $error("instr_done longer than one cycle");

  // the next instruction needs at least fetch and decode
  assert property (@(posedge clk) disable iff (!arst_n)
    instr_done |=> !instr_done ##1 !instr_done)
    else $error("instr_done came back too early");

  assert property (@(posedge clk) disable iff (!arst_n)
    instr_done ##1 !instr_done ##1 !instr_done ##1 !instr_done |=> instr_done)
    else $error("instr_done later than four cycles");

  // the fetch address holds at the pc until the instruction ends
  assert property (@(posedge clk) disable iff (!arst_n)
    !instr_done |=> rom_addr == $past(state.pc))
    else $error("rom_addr moved away from pc in the middle of an instruction");

endmodule

bind cpu cpu_bus_checks i_bus_checks (.*);

// ==== tests/bench.sv ====
`timescale 1ns/1ps

module bench import cpu_pkg::*; ();

  typedef struct {
    string                   name;
    logic [rom_width-1:0]    word;
    int                      reps;
    int                      len;
    bit                      init_ram;
    logic [nibble_width-1:0] mem_x;
    logic [nibble_width-1:0] mem_y;
    cpu_state_t              exp;
    bit                      store_chk;
    logic [ptr_width-1:0]    store_addr;
    logic [nibble_width-1:0] store_data;
  } test_t;

  logic                    clk;
  logic                    arst_n;
  logic [pc_width-1:0]     rom_addr;
  logic [rom_width-1:0]    rom_data;
  logic                    memory_write_en;
  logic [ptr_width-1:0]    memory_addr;
  logic [nibble_width-1:0] memory_write_data;
  logic [nibble_width-1:0] memory_read_data;
  cpu_state_t              state;
  logic                    instr_done;

  logic [rom_width-1:0]    rom [0:(1 << pc_width) - 1];
  logic [nibble_width-1:0] ram [0:(1 << ptr_width) - 1];
  logic [pc_width-1:0]     rom_addr_q;
  logic [ptr_width-1:0]    ram_addr_q;
  logic                    we_q;
  logic [nibble_width-1:0] wdata_q;

  test_t  tests[$];
  int     errors;
  int     passed;
  int     failed;
  bit     table_ready;
  longint limit_ns;

  cpu i_cpu (
    .clk               (clk),
    .arst_n            (arst_n),
    .rom_addr          (rom_addr),
    .rom_data          (rom_data),
    .memory_write_en   (memory_write_en),
    .memory_addr       (memory_addr),
    .memory_write_data (memory_write_data),
    .memory_read_data  (memory_read_data),
    .state             (state),
    .instr_done        (instr_done)
  );

  always #20 clk = ~clk;

  // bus values are taken mid-cycle and answered just after the next rising edge
  always @(negedge clk) begin
    rom_addr_q <= rom_addr;
    ram_addr_q <= memory_addr;
    we_q       <= memory_write_en;
    wdata_q    <= memory_write_data;
  end

  always @(posedge clk) begin
    #1;
    if (we_q) begin
      ram[ram_addr_q] = wdata_q;
    end
    rom_data         = rom[rom_addr_q];
    memory_read_data = ram[ram_addr_q];
  end

  function automatic cpu_state_t st(int pc, int a, int b, int x, int y, int c, int z);
    cpu_state_t s;
    s.pc    = pc[pc_width-1:0];
    s.a     = a[nibble_width-1:0];
    s.b     = b[nibble_width-1:0];
    s.x     = x[ptr_width-1:0];
    s.y     = y[ptr_width-1:0];
    s.carry = c[0];
    s.zero  = z[0];
    return s;
  endfunction

  // add sets carry above 15, sub sets it when the operand exceeds a
  function automatic cpu_state_t model_arith(cpu_state_t s, opcode_e op, operand_e r,
                                             logic [nibble_width-1:0] mx,
                                             logic [nibble_width-1:0] my);
    cpu_state_t n;
    int         v;
    int         res;
    n = s;
    case (r)
      r_a:     v = int'(s.a);
      r_b:     v = int'(s.b);
      r_mx:    v = int'(mx);
      default: v = int'(my);
    endcase
    if (op == add_r) begin
      res     = int'(s.a) + v;
      n.carry = (res > 15);
    end else begin
      res     = int'(s.a) - v;
      n.carry = (v > int'(s.a));
    end
    n.a    = res[nibble_width-1:0];
    n.zero = (n.a == 4'h0);
    n.pc   = s.pc + 13'd1;
    return n;
  endfunction

  task automatic add_test(string name, logic [rom_width-1:0] word, int reps, int len,
                          cpu_state_t exp);
    test_t t;
    t = '{name: name, word: word, reps: reps, len: len, init_ram: 0, mem_x: 0,
          mem_y: 0, exp: exp, store_chk: 0, store_addr: 0, store_data: 0};
    tests.push_back(t);
  endtask

  task automatic set_ram(logic [nibble_width-1:0] mx, logic [nibble_width-1:0] my);
    test_t t;
    t          = tests.pop_back();
    t.init_ram = 1;
    t.mem_x    = mx;
    t.mem_y    = my;
    tests.push_back(t);
  endtask

  task automatic set_store(logic [ptr_width-1:0] addr, logic [nibble_width-1:0] data);
    test_t t;
    t            = tests.pop_back();
    t.store_chk  = 1;
    t.store_addr = addr;
    t.store_data = data;
    tests.push_back(t);
  endtask

  task automatic build_table();
    add_test("lda_i", 12'h105, 1, 3, st('h001, 5, 0, 'h000, 'h000, 0, 0));
    add_test("ldb_i", 12'h203, 1, 3, st('h002, 5, 3, 'h000, 'h000, 0, 0));
    add_test("ldx_i", 12'h3ff, 1, 3, st('h003, 5, 3, 'h0ff, 'h000, 0, 0));
    add_test("ldy_i", 12'h480, 1, 3, st('h004, 5, 3, 'h0ff, 'h080, 0, 0));
    add_test("add_b", 12'h540, 1, 3, st('h005, 8, 3, 'h0ff, 'h080, 0, 0));
    add_test("add_mx", 12'h580, 1, 4, st('h006, 1, 3, 'h0ff, 'h080, 1, 0));
    set_ram(4'h9, 4'h0);
    add_test("sub_my", 12'h6c0, 1, 4, st('h007, 0, 3, 'h0ff, 'h080, 0, 1));
    set_ram(4'h9, 4'h1);
    add_test("jz_taken", 12'hd20, 1, 3, st('h020, 0, 3, 'h0ff, 'h080, 0, 1));
    add_test("jc_fall", 12'he40, 1, 3, st('h021, 0, 3, 'h0ff, 'h080, 0, 1));
    add_test("sub_borrow", 12'h640, 1, 3, st('h022, 13, 3, 'h0ff, 'h080, 1, 0));
    add_test("jc_taken", 12'he30, 1, 3, st('h030, 13, 3, 'h0ff, 'h080, 1, 0));
    add_test("jz_fall", 12'hd10, 1, 3, st('h031, 13, 3, 'h0ff, 'h080, 1, 0));
    add_test("st_mx", 12'h980, 1, 3, st('h032, 13, 3, 'h0ff, 'h080, 1, 0));
    set_store(12'h0ff, 4'hd);
    add_test("st_my", 12'h9c0, 1, 3, st('h033, 13, 3, 'h0ff, 'h080, 1, 0));
    set_store(12'h080, 4'hd);
    // memory at x differs from a, so a stray write would show
    add_test("st_a", 12'h900, 1, 3, st('h034, 13, 3, 'h0ff, 'h080, 1, 0));
    set_ram(4'h7, 4'h7);
    set_store(12'h0ff, 4'h7);
    add_test("ld_mx", 12'h880, 1, 4, st('h035, 6, 3, 'h0ff, 'h080, 1, 0));
    set_ram(4'h6, 4'h0);
    add_test("and_b", 12'h740, 1, 3, st('h036, 2, 3, 'h0ff, 'h080, 1, 0));
    add_test("xab", 12'hb00, 1, 3, st('h037, 3, 2, 'h0ff, 'h080, 1, 0));
    add_test("inc_x_run", 12'ha00, 'hf00, 3, st('hf37, 3, 2, 'hfff, 'h080, 1, 0));
    add_test("inc_x_wrap", 12'ha00, 1, 3, st('hf38, 3, 2, 'h000, 'h080, 1, 0));
    add_test("ldy_i_ff", 12'h4ff, 1, 3, st('hf39, 3, 2, 'h000, 'h0ff, 1, 0));
    add_test("inc_y_run", 12'ha40, 'hf00, 3, st('h1e39, 3, 2, 'h000, 'hfff, 1, 0));
    add_test("inc_y_wrap", 12'ha40, 1, 3, st('h1e3a, 3, 2, 'h000, 'h000, 1, 0));
    add_test("jmp_page", 12'hc05, 1, 3, st('h1e05, 3, 2, 'h000, 'h000, 1, 0));
    add_test("ldx_i_12", 12'h312, 1, 3, st('h1e06, 3, 2, 'h012, 'h000, 1, 0));
    add_test("ldy_i_34", 12'h434, 1, 3, st('h1e07, 3, 2, 'h012, 'h034, 1, 0));
  endtask

  task automatic add_random();
    cpu_state_t              prev;
    opcode_e                 op;
    operand_e                r;
    logic [nibble_width-1:0] mx;
    logic [nibble_width-1:0] my;
    for (int i = 0; i < 32; i++) begin
      prev = tests[tests.size() - 1].exp;
      op   = ($urandom % 2) ? add_r : sub_r;
      r    = operand_e'($urandom % 4);
      mx   = 4'($urandom);
      my   = 4'($urandom);
      add_test($sformatf("rand_%0d", i), {op, r, 6'b0}, 1, (r == r_mx || r == r_my) ? 4 : 3,
               model_arith(prev, op, r, mx, my));
      set_ram(mx, my);
    end
  endtask

  task automatic check_state(string name, cpu_state_t exp, cpu_state_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected state %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_nibble(string name, logic [nibble_width-1:0] exp,
                              logic [nibble_width-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected nibble %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_length(string name, int exp, int act);
    if (act != exp) begin
      $display("[ERROR] %s: expected %0d cycles, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(string name, logic [pc_width-1:0] exp, logic [pc_width-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected rom_addr %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(string name, int errs_before);
    if (errors == errs_before) begin
      passed++;
      $display("[PASS] %s", name);
    end else begin
      failed++;
      $display("[FAIL] %s", name);
    end
  endtask

  task automatic run_test(test_t t);
    int errs_before;
    int cycles;
    bit done_seen;
    errs_before = errors;
    for (int rep = 0; rep < t.reps; rep++) begin
      rom[state.pc] = t.word;
      if (t.init_ram) begin
        ram[state.x] = t.mem_x;
        ram[state.y] = t.mem_y;
      end
      cycles    = 0;
      done_seen = 0;
      while (!done_seen) begin
        @(negedge clk);
        cycles++;
        done_seen = instr_done;
      end
      @(posedge clk);
      #2;
      check_length(t.name, t.len, cycles);
    end
    check_state(t.name, t.exp, state);
    if (t.store_chk) begin
      check_nibble(t.name, t.store_data, ram[t.store_addr]);
    end
    finish_test(t.name, errs_before);
  endtask

  initial begin
    longint total;
    clk              = 1'b0;
    arst_n           = 1'b0;
    rom_data         = '0;
    memory_read_data = '0;
    errors           = 0;
    passed           = 0;
    failed           = 0;
    table_ready      = 0;
    void'($urandom(32'h9634_03ec));
    for (int i = 0; i < (1 << pc_width); i++) begin
      rom[i] = '0;
    end
    for (int i = 0; i < (1 << ptr_width); i++) begin
      ram[i] = 4'(i) ^ 4'(i >> 4) ^ 4'(i >> 8);
    end
    build_table();
    total = 32;
    foreach (tests[i]) begin
      total += tests[i].reps;
    end
    add_random();
    limit_ns    = total * 6 * 40;
    table_ready = 1;

    repeat (4) @(posedge clk);
    #1 arst_n = 1'b1;
    #1;
    check_state("reset", '0, state);
    check_addr("reset", '0, rom_addr);
    finish_test("reset", 0);

    foreach (tests[i]) begin
      run_test(tests[i]);
    end

    $display("tests passed %0d, failed %0d", passed, failed);
    if (failed == 0 && errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    #(limit_ns);
    $display("timeout: instr_done never came within %0d ns", limit_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== project.f ====
src/cpu_pkg.sv
src/cpu_microcode.sv
src/cpu_regs.sv
src/cpu_alu.sv
src/cpu_addr_unit.sv
src/cpu.sv
tests/bench_assert.sv
tests/bench.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the bench with Verilator and runs it once.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module bench -f project.f -o bench_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

output=$(./obj_dir/bench_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASSED" <<< "$output"; then
  exit 0
fi
exit 1
